// ==== rtl/cpu_backend_defs.svh ====
`ifndef CPU_BACKEND_DEFS_SVH
`define CPU_BACKEND_DEFS_SVH

// One machine word, also the width of an address
`define CPU_DATA_W 32

// Register file destination index
`define CPU_REG_ADDR_W 5

// Word address bits into the data RAM, 256 words
`define CPU_DMEM_ADDR_W 8

// Byte offset bits below the word address
`define CPU_WORD_OFS_W 2

`endif

// ==== rtl/cpu_backend_pkg.sv ====
`include "cpu_backend_defs.svh"

package cpu_backend_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,                         // Also drives the branch zero test
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5                          // Signed compare
    } alu_op_e;

    // Write-back control, carried from execute to write-back
    typedef struct packed {
        logic                       mem_to_reg; // Load data instead of ALU result
        logic                       reg_write;
        logic [`CPU_REG_ADDR_W-1:0] reg_dest;
    } wb_ctrl_t;

    typedef struct packed {
        logic     valid;
        logic     mem_read;
        logic     mem_write;
        wb_ctrl_t wb;
    } ex_mem_ctrl_t;

    typedef struct packed {
        logic     valid;
        wb_ctrl_t wb;
    } mem_wb_ctrl_t;

endpackage

// ==== rtl/stage_if.sv ====
`timescale 1ns/1ps
`include "cpu_backend_defs.svh"

// Pipeline register bundle between two stages
interface stage_if #(
    parameter type ctrl_t = logic
);

    ctrl_t                  ctrl;
    logic [`CPU_DATA_W-1:0] result;   // ALU result
    logic [`CPU_DATA_W-1:0] data;     // Store data or loaded word

    modport src (
        output ctrl,
        output result,
        output data
    );

    modport dst (
        input ctrl,
        input result,
        input data
    );

endinterface

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_backend_defs.svh"

module execute_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  cpu_backend_pkg::alu_op_e  alu_op,
    input  logic [`CPU_DATA_W-1:0]    operand_a,
    input  logic [`CPU_DATA_W-1:0]    operand_b,
    input  logic [`CPU_DATA_W-1:0]    store_data,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic                      is_branch,
    input  cpu_backend_pkg::wb_ctrl_t wb_ctrl,
    output logic                      branch_taken,
    stage_if.src                      ex_mem
);

    cpu_backend_pkg::alu_op_e  op_q;
    cpu_backend_pkg::wb_ctrl_t wb_q;
    logic [`CPU_DATA_W-1:0]    a_q;
    logic [`CPU_DATA_W-1:0]    b_q;
    logic [`CPU_DATA_W-1:0]    sd_q;
    logic                      valid_q;
    logic                      rd_q;
    logic                      wr_q;
    logic                      br_q;
    logic [`CPU_DATA_W-1:0]    sub_res;
    logic [`CPU_DATA_W-1:0]    alu_res;
    logic                      branch_q;

    // Issue register, commands only live with issue_valid
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            valid_q <= 1'b0;
            rd_q    <= 1'b0;
            wr_q    <= 1'b0;
            br_q    <= 1'b0;
            wb_q    <= '0;
        end
        else
        begin
            valid_q <= issue_valid;
            rd_q    <= issue_valid & mem_read;
            wr_q    <= issue_valid & mem_write;
            br_q    <= issue_valid & is_branch;
            wb_q    <= issue_valid ? wb_ctrl : '0;
        end
    end

    always_ff @(posedge clk)
    begin
        op_q <= alu_op;
        a_q  <= operand_a;
        b_q  <= operand_b;
        sd_q <= store_data;
    end

    assign sub_res = a_q - b_q;

    always_comb
    begin
        case (op_q)
            cpu_backend_pkg::ALU_ADD: alu_res = a_q + b_q;
            cpu_backend_pkg::ALU_SUB: alu_res = sub_res;
            cpu_backend_pkg::ALU_AND: alu_res = a_q & b_q;
            cpu_backend_pkg::ALU_OR:  alu_res = a_q | b_q;
            cpu_backend_pkg::ALU_XOR: alu_res = a_q ^ b_q;
            cpu_backend_pkg::ALU_SLT: alu_res = {{(`CPU_DATA_W-1){1'b0}},
                                                 $signed(a_q) < $signed(b_q)};
            default:                  alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ex_mem.ctrl  <= '0;
            branch_q     <= 1'b0;
            branch_taken <= 1'b0;
        end
        else
        begin
            ex_mem.ctrl  <= '{valid: valid_q, mem_read: rd_q, mem_write: wr_q, wb: wb_q};
            branch_q     <= valid_q & br_q & (sub_res == '0);  // Equal operands
            branch_taken <= branch_q;                          // Extra cycle of delay
        end
    end

    always_ff @(posedge clk)
    begin
        ex_mem.result <= alu_res;
        ex_mem.data   <= sd_q;
    end

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ps
`include "cpu_backend_defs.svh"

module memory_stage (
    input  logic                        clk,
    input  logic                        rst,
    stage_if.dst                        ex_mem,
    output logic [`CPU_DMEM_ADDR_W-1:0] ram_addr,
    output logic [`CPU_DATA_W-1:0]      ram_wdata,
    output logic                        ram_we,
    input  logic [`CPU_DATA_W-1:0]      ram_rdata,
    output logic                        mem_done,
    stage_if.src                        mem_wb
);

    logic [`CPU_DATA_W-1:0]    addr_q;    // Full ALU result, byte address
    logic [`CPU_DATA_W-1:0]    wdata_q;
    logic                      acc_valid;
    logic                      acc_read;
    logic                      acc_write;
    cpu_backend_pkg::wb_ctrl_t acc_wb;

    // Access register, feeds the RAM port directly
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            acc_valid <= 1'b0;
            acc_read  <= 1'b0;
            acc_write <= 1'b0;
            acc_wb    <= '0;
        end
        else
        begin
            acc_valid <= ex_mem.ctrl.valid;
            acc_read  <= ex_mem.ctrl.valid & ex_mem.ctrl.mem_read;
            acc_write <= ex_mem.ctrl.valid & ex_mem.ctrl.mem_write;
            acc_wb    <= ex_mem.ctrl.wb;
        end
    end

    always_ff @(posedge clk)
    begin
        addr_q  <= ex_mem.result;
        wdata_q <= ex_mem.data;
    end

    // Word index, byte offset dropped
    assign ram_addr  = addr_q[`CPU_DMEM_ADDR_W+`CPU_WORD_OFS_W-1:`CPU_WORD_OFS_W];
    assign ram_wdata = wdata_q;
    assign ram_we    = acc_valid & acc_write;

    // Second register lines the control up with the RAM read word
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mem_done    <= 1'b0;
            mem_wb.ctrl <= '0;
        end
        else
        begin
            mem_done    <= acc_valid & (acc_read | acc_write);  // Cleared on idle cycles
            mem_wb.ctrl <= '{valid: acc_valid, wb: acc_wb};
        end
    end

    always_ff @(posedge clk)
    begin
        mem_wb.result <= addr_q;
    end

    assign mem_wb.data = ram_rdata;  // Already registered inside the RAM

endmodule

// ==== rtl/data_ram.sv ====
`timescale 1ns/1ps
`include "cpu_backend_defs.svh"

module data_ram (
    input  logic                        clk,
    input  logic [`CPU_DMEM_ADDR_W-1:0] addr,
    input  logic [`CPU_DATA_W-1:0]      wdata,
    input  logic                        we,
    output logic [`CPU_DATA_W-1:0]      rdata
);

    localparam int DEPTH = 1 << `CPU_DMEM_ADDR_W;

    logic [`CPU_DATA_W-1:0] mem [DEPTH];

    // Single port, write has priority over the read
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata;
        end
        else
        begin
            rdata <= mem[addr];  // One cycle read latency
        end
    end

endmodule

// ==== rtl/writeback_stage.sv ====
`timescale 1ns/1ps
`include "cpu_backend_defs.svh"

module writeback_stage (
    input  logic                       clk,
    input  logic                       rst,
    stage_if.dst                       mem_wb,
    output logic                       wb_en,
    output logic [`CPU_REG_ADDR_W-1:0] wb_dest,
    output logic [`CPU_DATA_W-1:0]     wb_data
);

    logic [`CPU_DATA_W-1:0] wb_sel;
    logic                   wb_write;

    // Loaded word for loads, ALU result for everything else
    assign wb_sel = mem_wb.ctrl.wb.mem_to_reg ? mem_wb.data : mem_wb.result;

    // Register zero is hardwired, never written
    assign wb_write = mem_wb.ctrl.valid
                    & mem_wb.ctrl.wb.reg_write
                    & (mem_wb.ctrl.wb.reg_dest != '0);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_en <= 1'b0;
        end
        else
        begin
            wb_en <= wb_write;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_dest <= mem_wb.ctrl.wb.reg_dest;
        wb_data <= wb_sel;
    end

endmodule

// ==== rtl/cpu_backend.sv ====
`timescale 1ns/1ps
`include "cpu_backend_defs.svh"

module cpu_backend (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       issue_valid,
    input  cpu_backend_pkg::alu_op_e   alu_op,
    input  logic [`CPU_DATA_W-1:0]     operand_a,
    input  logic [`CPU_DATA_W-1:0]     operand_b,
    input  logic [`CPU_DATA_W-1:0]     store_data,
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  logic                       is_branch,
    input  logic                       mem_to_reg,
    input  logic                       reg_write,
    input  logic [`CPU_REG_ADDR_W-1:0] reg_dest,
    output logic                       branch_taken,
    output logic                       mem_done,
    output logic                       wb_en,
    output logic [`CPU_REG_ADDR_W-1:0] wb_dest,
    output logic [`CPU_DATA_W-1:0]     wb_data
);

    cpu_backend_pkg::wb_ctrl_t     wb_ctrl;
    logic [`CPU_DMEM_ADDR_W-1:0]   ram_addr;
    logic [`CPU_DATA_W-1:0]        ram_wdata;
    logic [`CPU_DATA_W-1:0]        ram_rdata;
    logic                          ram_we;

    assign wb_ctrl = '{mem_to_reg: mem_to_reg, reg_write: reg_write, reg_dest: reg_dest};

    stage_if #(.ctrl_t(cpu_backend_pkg::ex_mem_ctrl_t)) ex_mem ();
    stage_if #(.ctrl_t(cpu_backend_pkg::mem_wb_ctrl_t)) mem_wb ();

    execute_stage execute_stage_i (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .alu_op       (alu_op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .store_data   (store_data),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .is_branch    (is_branch),
        .wb_ctrl      (wb_ctrl),
        .branch_taken (branch_taken),
        .ex_mem       (ex_mem.src)
    );

    memory_stage memory_stage_i (
        .clk       (clk),
        .rst       (rst),
        .ex_mem    (ex_mem.dst),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata),
        .mem_done  (mem_done),
        .mem_wb    (mem_wb.src)
    );

    data_ram data_ram_i (
        .clk   (clk),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

    writeback_stage writeback_stage_i (
        .clk     (clk),
        .rst     (rst),
        .mem_wb  (mem_wb.dst),
        .wb_en   (wb_en),
        .wb_dest (wb_dest),
        .wb_data (wb_data)
    );

endmodule

// ==== tests/cpu_backend_assertions.sv ====
`timescale 1ns/1ps

module cpu_backend_assertions (
    input logic                      clk,
    input logic                      rst,
    input logic                      ex_valid,
    input logic                      ex_read,
    input logic                      ex_write,
    input logic                      acc_valid,
    input cpu_backend_pkg::wb_ctrl_t acc_wb,
    input logic                      ram_we,
    input logic                      mem_done
);

    int unsigned violations = 0;  // Polled by the testbench monitor

    logic ex_access;

    assign ex_access = ex_valid && (ex_read || ex_write);

    // The store entered the stage one cycle before it reaches the RAM
    we_only_for_store: assert property (@(posedge clk) disable iff (rst)
        ram_we |-> $past(ex_valid && ex_write))
        else
        begin
            $error("ram_we high without a valid store");
            violations++;
        end

    // Two done cycles in a row need two accesses in a row
    done_back_to_back: assert property (@(posedge clk) disable iff (rst)
        (mem_done && $past(mem_done)) |-> ($past(ex_access, 2) && $past(ex_access, 3)))
        else
        begin
            $error("mem_done held without back to back accesses");
            violations++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!mem_done && !ram_we))
        else
        begin
            $error("mem_done or ram_we high out of reset");
            violations++;
        end

    wb_needs_valid: assert property (@(posedge clk) disable iff (rst)
        acc_wb.reg_write |-> acc_valid)
        else
        begin
            $error("register write control without a valid operation");
            violations++;
        end

endmodule

// ==== tests/cpu_backend_tb.sv ====
`timescale 1ns/1ps
`include "cpu_backend_defs.svh"

module cpu_backend_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int ALU_OPS     = 60;
    localparam int GAP_OPS     = 25;
    localparam int TEST_CYCLES = 20 + ALU_OPS + 40 + 20 + GAP_OPS * 4 + 5 * 8;

    typedef struct {
        int unsigned                due;
        logic [`CPU_REG_ADDR_W-1:0] dest;
        logic [`CPU_DATA_W-1:0]     data;
    } wb_exp_t;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       issue_valid;
    cpu_backend_pkg::alu_op_e   alu_op;
    logic [`CPU_DATA_W-1:0]     operand_a;
    logic [`CPU_DATA_W-1:0]     operand_b;
    logic [`CPU_DATA_W-1:0]     store_data;
    logic                       mem_read;
    logic                       mem_write;
    logic                       is_branch;
    logic                       mem_to_reg;
    logic                       reg_write;
    logic [`CPU_REG_ADDR_W-1:0] reg_dest;
    logic                       branch_taken;
    logic                       mem_done;
    logic                       wb_en;
    logic [`CPU_REG_ADDR_W-1:0] wb_dest;
    logic [`CPU_DATA_W-1:0]     wb_data;

    wb_exp_t                wb_q[$];
    int unsigned            done_q[$];
    int unsigned            br_q[$];
    logic [`CPU_DATA_W-1:0] shadow [1 << `CPU_DMEM_ADDR_W];
    int                     stored[$];     // Word addresses written so far
    int unsigned            cyc = 0;
    bit                     checking = 1'b0;

    cpu_backend cpu_backend_i (.*);

    bind memory_stage cpu_backend_assertions mem_checks (
        .clk(clk), .rst(rst), .ex_valid(ex_mem.ctrl.valid), .ex_read(ex_mem.ctrl.mem_read),
        .ex_write(ex_mem.ctrl.mem_write), .acc_valid(acc_valid), .acc_wb(acc_wb),
        .ram_we(ram_we), .mem_done(mem_done)
    );

    always #(CLK_PERIOD / 2.0) clk = ~clk;

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    function automatic logic [`CPU_DATA_W-1:0] alu_model(cpu_backend_pkg::alu_op_e op,
            logic [`CPU_DATA_W-1:0] a, logic [`CPU_DATA_W-1:0] b);
        case (op)
            cpu_backend_pkg::ALU_ADD: return a + b;
            cpu_backend_pkg::ALU_SUB: return a - b;
            cpu_backend_pkg::ALU_AND: return a & b;
            cpu_backend_pkg::ALU_OR:  return a | b;
            cpu_backend_pkg::ALU_XOR: return a ^ b;
            cpu_backend_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 1 : 0;
            default:                  return '0;
        endcase
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        abort_run();
    endtask

    task automatic report_problem(string what);
        $display("%s", what);
        abort_run();
    endtask

    // Drive one operation and record what it must produce later
    task automatic issue(cpu_backend_pkg::alu_op_e op, logic [31:0] a, logic [31:0] b,
            logic [31:0] sd, bit rd, bit wr, bit br, bit rw, logic [4:0] dest);
        int unsigned n;
        logic [31:0] res;
        int          idx;
        wb_exp_t     e;
        n           = cyc + 1;                 // Edge that samples this issue
        res         = alu_model(op, a, b);
        idx         = res[`CPU_DMEM_ADDR_W+1:2];
        issue_valid = 1'b1;
        alu_op      = op;
        operand_a   = a;
        operand_b   = b;
        store_data  = sd;
        mem_read    = rd;
        mem_write   = wr;
        is_branch   = br;
        mem_to_reg  = rd;
        reg_write   = rw;
        reg_dest    = dest;
        if (wr)
        begin
            shadow[idx] = sd;
            stored.push_back(idx);
        end
        if (rd || wr)
            done_q.push_back(n + 3);
        if (br && a == b)
            br_q.push_back(n + 2);
        if (rw && dest != 0)
        begin
            e.due  = n + 4;
            e.dest = dest;
            e.data = rd ? shadow[idx] : res;
            wb_q.push_back(e);
        end
        @(posedge clk);
        #0.5;
    endtask

    task automatic idle_cycle();
        issue_valid = 1'b0;
        mem_write   = $urandom_range(1);       // Must be ignored without issue_valid
        reg_write   = $urandom_range(1);
        is_branch   = $urandom_range(1);
        store_data  = $urandom;
        @(posedge clk);
        #0.5;
    endtask

    task automatic drain();
        repeat (8) idle_cycle();
    endtask

    task automatic store_word(int w);
        logic [31:0] base;
        logic [31:0] addr;
        base = $urandom;
        addr = ($urandom & 32'hffff_fc00) | (w << 2);  // Bits above the RAM index are ignored
        issue(cpu_backend_pkg::ALU_ADD, base, addr - base, $urandom, 0, 1, 0, 0,
              $urandom_range(31));
    endtask

    task automatic load_word(int w);
        issue(cpu_backend_pkg::ALU_ADD, w << 2, '0, '0, 1, 0, 0, 1, $urandom_range(31, 1));
    endtask

    // Compare outputs against the expected events due this cycle
    task automatic check_outputs();
        bit      want_wb;
        bit      want_done;
        bit      want_br;
        wb_exp_t e;
        want_wb   = wb_q.size() > 0 && wb_q[0].due == cyc;
        want_done = done_q.size() > 0 && done_q[0] == cyc;
        want_br   = br_q.size() > 0 && br_q[0] == cyc;
        assert (wb_en === want_wb)
            else report_mismatch("wb_en", wb_en, want_wb);
        assert (mem_done === want_done)
            else report_mismatch("mem_done", mem_done, want_done);
        assert (branch_taken === want_br)
            else report_mismatch("branch_taken", branch_taken, want_br);
        assert (cpu_backend_i.memory_stage_i.mem_checks.violations == 0)
            else report_problem("A concurrent assertion on the memory stage failed");
        if (want_done)
            void'(done_q.pop_front());
        if (want_br)
            void'(br_q.pop_front());
        if (want_wb)
        begin
            e = wb_q.pop_front();
            assert (wb_dest === e.dest)
                else report_mismatch("wb_dest", wb_dest, e.dest);
            assert (wb_data === e.data)
                else report_mismatch("wb_data", wb_data, e.data);
        end
    endtask

    always @(negedge clk)
    begin
        if (checking)
            check_outputs();
    end

    task automatic test_reset();
        repeat (10)
        begin
            idle_cycle();
            assert (!wb_en && !mem_done && !branch_taken)
                else report_problem("An output went high during idle cycles after reset");
        end
    endtask

    task automatic test_alu();
        cpu_backend_pkg::alu_op_e ops[6];
        ops = '{cpu_backend_pkg::ALU_ADD, cpu_backend_pkg::ALU_SUB, cpu_backend_pkg::ALU_AND,
                cpu_backend_pkg::ALU_OR, cpu_backend_pkg::ALU_XOR, cpu_backend_pkg::ALU_SLT};
        for (int i = 0; i < ALU_OPS; i++)
            issue(ops[i % 6], $urandom, $urandom, '0, 0, 0, 0, 1, $urandom_range(31, 1));
        drain();
    endtask

    task automatic test_store_load();
        int w;
        for (int i = 0; i < 16; i++)
        begin
            w = $urandom_range(255);
            store_word(w);
            if (i % 2)
                load_word(w);                  // Load right behind its store
        end
        for (int i = 0; i < 16; i++)
            load_word(stored[$urandom_range(stored.size() - 1)]);
        drain();
    endtask

    task automatic test_branch();
        logic [31:0] a;
        for (int i = 0; i < 20; i++)
        begin
            a = $urandom;
            issue(cpu_backend_pkg::ALU_SUB, a, (i % 2) ? a : $urandom, '0, 0, 0, i < 16,
                  i >= 16, $urandom_range(31, 1));
        end
        drain();
    endtask

    task automatic test_zero_and_gaps();
        for (int i = 0; i < GAP_OPS; i++)
        begin
            repeat ($urandom_range(3)) idle_cycle();
            case (i % 5)
                0: issue(cpu_backend_pkg::ALU_XOR, $urandom, $urandom, '0, 0, 0, 0, 1, '0);
                1: issue(cpu_backend_pkg::ALU_OR, $urandom, $urandom, '0, 0, 0, 0, 0,
                         $urandom_range(31, 1));
                2: load_word(stored[$urandom_range(stored.size() - 1)]);
                3: store_word($urandom_range(255));
                default: issue(cpu_backend_pkg::ALU_ADD, $urandom, $urandom, '0, 0, 0, 0, 1,
                               $urandom_range(31, 1));
            endcase
        end
        drain();
    endtask

    initial
    begin
        #((TEST_CYCLES + 200) * CLK_PERIOD);
        $display("Timeout, the tests did not finish within %0d cycles", TEST_CYCLES + 200);
        $display("FAIL: see errors above");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        void'($urandom(32'hf947));
        rst         = 1'b1;
        issue_valid = 1'b0;
        alu_op      = cpu_backend_pkg::ALU_ADD;
        operand_a   = '0;
        operand_b   = '0;
        store_data  = '0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        is_branch   = 1'b0;
        mem_to_reg  = 1'b0;
        reg_write   = 1'b0;
        reg_dest    = '0;
        repeat (10) @(posedge clk);
        #0.5;
        rst      = 1'b0;
        checking = 1'b1;
        test_reset();
        test_alu();
        test_store_load();
        test_branch();
        test_zero_and_gaps();
        assert (wb_q.size() == 0 && done_q.size() == 0 && br_q.size() == 0)
            else report_problem("Some expected outputs never arrived");
        assert (cpu_backend_i.memory_stage_i.mem_checks.violations == 0)
            else report_problem("A concurrent assertion on the memory stage failed");
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/cpu_backend_pkg.sv
rtl/stage_if.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/data_ram.sv
rtl/writeback_stage.sv
rtl/cpu_backend.sv
tests/cpu_backend_assertions.sv
tests/cpu_backend_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_backend

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/cpu_backend_pkg.sv
      - rtl/stage_if.sv
      - rtl/execute_stage.sv
      - rtl/memory_stage.sv
      - rtl/data_ram.sv
      - rtl/writeback_stage.sv
      - rtl/cpu_backend.sv
  - target: test
    files:
      - tests/cpu_backend_assertions.sv
      - tests/cpu_backend_tb.sv
